//--- files.f
+incdir+logic
logic/pi1_axi_pkg.sv
logic/pi1_to_axi4.sv
logic/axi4_sram_slave.sv
logic/pi1_axi_top.sv
sim/pi1_axi_assertions.sv
sim/pi1_axi_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module pi1_axi_tb -Mdir obj_dir
	./obj_dir/Vpi1_axi_tb

clean:
	rm -rf obj_dir

//--- sim/pi1_axi_trace.txt
// Columns are op, word address, write data, byte select, expected read word (hex).
// Op 0 is no-operation, 1 write, 2 read, 3 read-swap.
0 00000000 00000000 0 00000000
// Full-select write then read back.
1 00000004 deadbeef f 00000000
2 00000004 00000000 f deadbeef
// Partial selects merge into the stored word.
1 00000005 11223344 f 00000000
1 00000005 aabbccdd 6 00000000
2 00000005 00000000 f 11bbcc44
1 00000006 a5a5a5a5 1 00000000
1 00000006 5a5a5a5a 8 00000000
2 00000006 00000000 f 5a0000a5
// Read-swap returns the old word and merges the new one.
3 00000004 cafef00d f deadbeef
2 00000004 00000000 f cafef00d
3 00000005 99887766 3 11bbcc44
2 00000005 00000000 f 11bb7766
3 00000005 01020304 c 11bb7766
2 00000005 00000000 f 01027766
// Unwritten words read as zero.
2 00000010 00000000 f 00000000
2 0000003f 00000000 f 00000000
// Addresses beyond the depth wrap onto the lower words.
1 00000047 12345678 f 00000000
2 00000007 00000000 f 12345678
2 00000087 00000000 f 12345678
1 3fffffc8 0badf00d f 00000000
2 00000008 00000000 f 0badf00d
0 00000000 00000000 0 00000000
2 00000004 00000000 f cafef00d
3 00000044 ffffffff f cafef00d
2 00000004 00000000 f ffffffff
0 00000000 00000000 0 00000000

//--- sim/pi1_axi_tb.sv
//////////////////////////////
// Trace-driven testbench for the PI1 to AXI4 memory port.
//////////////////////////////
`include "pi1_axi_cfg.svh"

module pi1_axi_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import pi1_axi_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_OP = 20;
	localparam int MAX_OPS = 64;
	localparam int COLS = 5;
	localparam int DATA_W = `PI1_AXI_ARCHBITSZ;

	logic clk_i;
	logic rst_i;
	pi1_req_t pi1_req_i;
	logic [DATA_W-1:0] pi1_data_o;
	logic pi1_rdy_o;
	logic [DATA_W-1:0] trace_mem [MAX_OPS*COLS];

	pi1_axi_top u_pi1_axi_top (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.pi1_req_i(pi1_req_i),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on the first failure.");
	endtask

	task automatic check_data(input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual, input string name);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_rdy(input logic expected, input logic actual, input string name);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk_i);
		$display("Timeout, the trace did not finish within %0d clock cycles.", cycles);
		abort_run();
	endtask

	function automatic pi1_req_t idle_req();
		return '{op: PI1_NOOP, addr: '0, data: '0, sel: '0};
	endfunction

	task automatic load_trace(output int n_ops);
		// Unused entries hold an address-dependent word that is no valid operation.
		for (int i = 0; i < MAX_OPS * COLS; i++)
			trace_mem[i] = DATA_W'(32'hdead_0000 + i);
		$readmemh("sim/pi1_axi_trace.txt", trace_mem);
		n_ops = 0;
		while (n_ops < MAX_OPS && trace_mem[n_ops*COLS] <= 3)
			n_ops++;
	endtask

	task automatic run_op(input int idx);
		pi1_req_t req;
		logic [DATA_W-1:0] expected;
		req.op = pi1_op_e'(trace_mem[idx*COLS][1:0]);
		req.addr = trace_mem[idx*COLS+1][`PI1_AXI_ADDRBITSZ-1:0];
		req.data = trace_mem[idx*COLS+2];
		req.sel = trace_mem[idx*COLS+3][DATA_W/8-1:0];
		expected = trace_mem[idx*COLS+4];
		@(posedge clk_i);
		#1;
		pi1_req_i = req;
		@(negedge clk_i);
		while (!pi1_rdy_o)
			@(negedge clk_i);
		// Accepted at the coming edge, then the bus is parked on a no-operation.
		@(posedge clk_i);
		#1;
		pi1_req_i = idle_req();
		@(negedge clk_i);
		// A no-operation answers at once, memory operations take longer.
		check_rdy(req.op == PI1_NOOP, pi1_rdy_o, $sformatf("pi1_rdy_o (operation %0d)", idx));
		while (!pi1_rdy_o)
			@(negedge clk_i);
		check_data(expected, pi1_data_o, $sformatf("pi1_data_o (operation %0d)", idx));
	endtask

	initial begin
		int n_ops;
		rst_i = 1'b1;
		pi1_req_i = idle_req();
		load_trace(n_ops);
		if (n_ops == 0) begin
			$display("The trace file holds no operations.");
			abort_run();
		end
		fork
			watchdog(RESET_CYCLES + (n_ops + 1) * CYCLES_PER_OP);
		join_none
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		@(negedge clk_i);
		check_rdy(1'b1, pi1_rdy_o, "pi1_rdy_o");
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		if (u_pi1_axi_top.u_sram.u_axi_checks.fail_cnt != 0) begin
			$display("AXI channel assertions failed during the run.");
			abort_run();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- sim/pi1_axi_assertions.sv
//////////////////////////////
// AXI handshake and response checks on the SRAM slave.
//////////////////////////////
`include "pi1_axi_cfg.svh"

module pi1_axi_assertions (
	input logic clk_i,
	input logic rst_i,
	input logic awvalid_i,
	input logic awready_i,
	input logic wvalid_i,
	input logic wready_i,
	input logic bvalid_i,
	input logic arvalid_i,
	input logic arready_i,
	input logic rvalid_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Sample edges from acceptance to the response cycle.
	localparam int RESP_DELAY = `PI1_AXI_SRAM_LATENCY + 1;

	int unsigned fail_cnt = 0;

	// A valid stays up until its handshake and drops right after it.
	aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		awvalid_i |=> ($past(awready_i) ? !awvalid_i : awvalid_i))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("awvalid did not hold until awready, or stayed up after it.");
		end

	w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		wvalid_i |=> ($past(wready_i) ? !wvalid_i : wvalid_i))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("wvalid did not hold until wready, or stayed up after it.");
		end

	ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		arvalid_i |=> ($past(arready_i) ? !arvalid_i : arvalid_i))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("arvalid did not hold until arready, or stayed up after it.");
		end

	// One-cycle pulse, a fixed time after an accepted write.
	b_resp: assert property (@(posedge clk_i) disable iff (rst_i)
		bvalid_i |-> !$past(bvalid_i) && $past(awvalid_i && wvalid_i && awready_i, RESP_DELAY))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("bvalid is not a single pulse after an accepted write.");
		end

	r_resp: assert property (@(posedge clk_i) disable iff (rst_i)
		rvalid_i |-> !$past(rvalid_i) && $past(arvalid_i && arready_i, RESP_DELAY))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("rvalid is not a single pulse after an accepted read.");
		end

endmodule

bind axi4_sram_slave pi1_axi_assertions u_axi_checks (
	.clk_i(clk_i), .rst_i(rst_i),
	.awvalid_i(awvalid_i), .awready_i(awready_o),
	.wvalid_i(wvalid_i), .wready_i(wready_o),
	.bvalid_i(bvalid_o),
	.arvalid_i(arvalid_i), .arready_i(arready_o),
	.rvalid_i(rvalid_o)
);

//--- logic/pi1_axi_top.sv
//////////////////////////////
// PI1 bridge feeding the AXI4 SRAM slave.
//////////////////////////////
`include "pi1_axi_cfg.svh"

module pi1_axi_top (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  pi1_axi_pkg::pi1_req_t         pi1_req_i,
	output logic [`PI1_AXI_ARCHBITSZ-1:0] pi1_data_o,
	output logic                          pi1_rdy_o
);
	import pi1_axi_pkg::*;

	axi_aw_t aw;
	axi_w_t  w;
	axi_b_t  b;
	axi_ar_t ar;
	axi_r_t  r;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;

	pi1_to_axi4 u_bridge (
		.clk_i(clk_i), .rst_i(rst_i),
		.pi1_req_i(pi1_req_i), .pi1_data_o(pi1_data_o), .pi1_rdy_o(pi1_rdy_o),
		.aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
		.w_o(w), .wvalid_o(wvalid), .wready_i(wready),
		.b_i(b), .bvalid_i(bvalid), .bready_o(bready),
		.ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
		.r_i(r), .rvalid_i(rvalid), .rready_o(rready)
	);

	axi4_sram_slave u_sram (
		.clk_i(clk_i), .rst_i(rst_i),
		.aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
		.w_i(w), .wvalid_i(wvalid), .wready_o(wready),
		.b_o(b), .bvalid_o(bvalid), .bready_i(bready),
		.ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
		.r_o(r), .rvalid_o(rvalid), .rready_i(rready)
	);

endmodule

//--- logic/axi4_sram_slave.sv
//////////////////////////////
// Single-beat AXI4 SRAM slave with a
// byte-strobed word memory and fixed latency.
//////////////////////////////
`include "pi1_axi_cfg.svh"

module axi4_sram_slave (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  pi1_axi_pkg::axi_aw_t aw_i,
	input  logic                 awvalid_i,
	output logic                 awready_o,
	input  pi1_axi_pkg::axi_w_t  w_i,
	input  logic                 wvalid_i,
	output logic                 wready_o,
	output pi1_axi_pkg::axi_b_t  b_o,
	output logic                 bvalid_o,
	input  logic                 bready_i,
	input  pi1_axi_pkg::axi_ar_t ar_i,
	input  logic                 arvalid_i,
	output logic                 arready_o,
	output pi1_axi_pkg::axi_r_t  r_o,
	output logic                 rvalid_o,
	input  logic                 rready_i
);
	localparam int SEL_W = `PI1_AXI_ARCHBITSZ / 8;
	localparam int OFF_W = $clog2(SEL_W);
	localparam int IDX_W = $clog2(`PI1_AXI_MEM_WORDS);
	localparam int CNT_W = $clog2(`PI1_AXI_SRAM_LATENCY + 1);

	logic [`PI1_AXI_ARCHBITSZ-1:0] mem [`PI1_AXI_MEM_WORDS];
	logic busy_q;
	logic resp_q;
	logic wr_q;
	logic [CNT_W-1:0] cnt_q;
	logic [`PI1_AXI_ID_WIDTH-1:0] id_q;
	logic [`PI1_AXI_ARCHBITSZ-1:0] rdata_q;
	logic idle;
	logic wr_acc;
	logic rd_acc;
	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx;

	assign idle = !busy_q && !resp_q;
	assign awready_o = idle;
	assign wready_o = idle;
	assign arready_o = idle;
	// Writes win if both address channels are valid.
	assign wr_acc = idle && awvalid_i && wvalid_i;
	assign rd_acc = idle && arvalid_i && !wr_acc;

	// Word index, upper address bits wrap at the depth.
	assign widx = aw_i.addr[OFF_W +: IDX_W];
	assign ridx = ar_i.addr[OFF_W +: IDX_W];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			resp_q <= 1'b0;
			wr_q <= 1'b0;
			cnt_q <= '0;
		end else if (wr_acc || rd_acc) begin
			busy_q <= 1'b1;
			wr_q <= wr_acc;
			cnt_q <= CNT_W'(`PI1_AXI_SRAM_LATENCY - 1);
		end else if (busy_q) begin
			if (cnt_q == '0) begin
				busy_q <= 1'b0;
				resp_q <= 1'b1;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end else if (resp_q && (wr_q ? bready_i : rready_i)) begin
			resp_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `PI1_AXI_MEM_WORDS; i++)
				mem[i] <= '0;
		end else if (wr_acc) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (w_i.strb[b])
					mem[widx][b*8 +: 8] <= w_i.data[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_acc)
			id_q <= aw_i.id;
		if (rd_acc) begin
			id_q <= ar_i.id;
			rdata_q <= mem[ridx];
		end
	end

	assign bvalid_o = resp_q && wr_q;
	assign rvalid_o = resp_q && !wr_q;
	assign b_o = '{id: id_q, resp: 2'b00};
	assign r_o = '{id: id_q, data: rdata_q, resp: 2'b00, last: 1'b1};

endmodule

//--- logic/pi1_to_axi4.sv
//////////////////////////////
// PI1 to AXI4 bridge, single-beat read, write
// and read-swap as a read then a write.
//////////////////////////////
`include "pi1_axi_cfg.svh"

module pi1_to_axi4 (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  pi1_axi_pkg::pi1_req_t         pi1_req_i,
	output logic [`PI1_AXI_ARCHBITSZ-1:0] pi1_data_o,
	output logic                          pi1_rdy_o,
	output pi1_axi_pkg::axi_aw_t          aw_o,
	output logic                          awvalid_o,
	input  logic                          awready_i,
	output pi1_axi_pkg::axi_w_t           w_o,
	output logic                          wvalid_o,
	input  logic                          wready_i,
	input  pi1_axi_pkg::axi_b_t           b_i,
	input  logic                          bvalid_i,
	output logic                          bready_o,
	output pi1_axi_pkg::axi_ar_t          ar_o,
	output logic                          arvalid_o,
	input  logic                          arready_i,
	input  pi1_axi_pkg::axi_r_t           r_i,
	input  logic                          rvalid_i,
	output logic                          rready_o
);
	import pi1_axi_pkg::*;

	localparam int SEL_W = `PI1_AXI_ARCHBITSZ / 8;
	localparam int OFF_W = `PI1_AXI_ARCHBITSZ - `PI1_AXI_ADDRBITSZ;
	localparam logic [`PI1_AXI_ID_WIDTH-1:0] AXI_ID = '0;
	localparam logic [2:0] AXI_SIZE = 3'($clog2(SEL_W));

	pi1_op_e op_q;
	logic cyc_q;
	logic we_q;
	logic wrpending_q;
	logic awvalid_q;
	logic wvalid_q;
	logic arvalid_q;
	logic bready_q;
	logic rready_q;
	logic [`PI1_AXI_ARCHBITSZ-1:0] addr_q;
	logic [`PI1_AXI_ARCHBITSZ-1:0] wdata_q;
	logic [`PI1_AXI_ARCHBITSZ-1:0] rdata_hold_q;
	logic [SEL_W-1:0] wstrb_q;
	logic ack;
	logic done;
	axi_aw_t ax;

	// Byte offset of the lowest selected byte.
	function automatic logic [OFF_W-1:0] low_offset(input logic [SEL_W-1:0] sel);
		logic [OFF_W-1:0] off;
		off = '0;
		for (int i = SEL_W - 1; i >= 0; i--) begin
			if (sel[i]) begin
				off = OFF_W'(i);
			end
		end
		return off;
	endfunction

	// Only responses carrying our own ID count.
	assign ack = we_q ? (bvalid_i && bready_q && (b_i.id == AXI_ID)) :
		(rvalid_i && rready_q && (r_i.id == AXI_ID));
	assign done = !wrpending_q && ack;
	assign pi1_rdy_o = !cyc_q || done;

	always_comb begin
		pi1_data_o = '0;
		if (done) begin
			case (op_q)
				PI1_RDOP: pi1_data_o = r_i.data;
				PI1_RWOP: pi1_data_o = rdata_hold_q;
				default:  pi1_data_o = '0;
			endcase
		end
	end

	// Read-swap writes back to the address it read.
	assign ax = '{id: AXI_ID, addr: addr_q, len: 8'd0, size: AXI_SIZE, burst: 2'b01,
		lock: 1'b0, cache: 4'd0, prot: 3'd0, qos: 4'd0};
	assign aw_o = ax;
	assign ar_o = ax;
	assign w_o = '{data: wdata_q, strb: wstrb_q, last: 1'b1};
	assign awvalid_o = awvalid_q;
	assign wvalid_o = wvalid_q;
	assign arvalid_o = arvalid_q;
	assign bready_o = bready_q;
	assign rready_o = rready_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			op_q <= PI1_NOOP;
			cyc_q <= 1'b0;
			we_q <= 1'b0;
			wrpending_q <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			arvalid_q <= 1'b0;
			bready_q <= 1'b0;
			rready_q <= 1'b0;
		end else begin
			// Each valid holds until its own ready.
			if (awvalid_q && awready_i)
				awvalid_q <= 1'b0;
			if (wvalid_q && wready_i)
				wvalid_q <= 1'b0;
			if (arvalid_q && arready_i)
				arvalid_q <= 1'b0;
			if (pi1_rdy_o) begin
				op_q <= pi1_req_i.op;
				bready_q <= 1'b0;
				rready_q <= 1'b0;
				case (pi1_req_i.op)
					PI1_RDOP, PI1_RWOP: begin
						cyc_q <= 1'b1;
						we_q <= 1'b0;
						wrpending_q <= (pi1_req_i.op == PI1_RWOP);
						arvalid_q <= 1'b1;
						rready_q <= 1'b1;
					end
					PI1_WROP: begin
						cyc_q <= 1'b1;
						we_q <= 1'b1;
						awvalid_q <= 1'b1;
						wvalid_q <= 1'b1;
						bready_q <= 1'b1;
					end
					default: begin
						cyc_q <= 1'b0;
						we_q <= 1'b0;
					end
				endcase
			end else if (wrpending_q && ack) begin
				// Read half of a read-swap is back, start the write.
				we_q <= 1'b1;
				wrpending_q <= 1'b0;
				rready_q <= 1'b0;
				awvalid_q <= 1'b1;
				wvalid_q <= 1'b1;
				bready_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (pi1_rdy_o) begin
			addr_q <= {pi1_req_i.addr, low_offset(pi1_req_i.sel)};
			wdata_q <= pi1_req_i.data;
			wstrb_q <= pi1_req_i.sel;
		end
		if (wrpending_q && ack)
			rdata_hold_q <= r_i.data;
	end

endmodule

//--- logic/pi1_axi_pkg.sv
//////////////////////////////
// PI1 operation and request types, AXI4 channel structs.
//////////////////////////////
`include "pi1_axi_cfg.svh"

package pi1_axi_pkg;

	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10,
		PI1_RWOP = 2'b11
	} pi1_op_e;

	typedef struct packed {
		pi1_op_e op;
		logic [`PI1_AXI_ADDRBITSZ-1:0] addr;
		logic [`PI1_AXI_ARCHBITSZ-1:0] data;
		logic [`PI1_AXI_ARCHBITSZ/8-1:0] sel;
	} pi1_req_t;

	// Write and read address channels share one layout.
	typedef struct packed {
		logic [`PI1_AXI_ID_WIDTH-1:0] id;
		logic [`PI1_AXI_ARCHBITSZ-1:0] addr;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [0:0] lock;
		logic [3:0] cache;
		logic [2:0] prot;
		logic [3:0] qos;
	} axi_aw_t;

	typedef axi_aw_t axi_ar_t;

	typedef struct packed {
		logic [`PI1_AXI_ARCHBITSZ-1:0] data;
		logic [`PI1_AXI_ARCHBITSZ/8-1:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic [`PI1_AXI_ID_WIDTH-1:0] id;
		logic [1:0] resp;
	} axi_b_t;

	typedef struct packed {
		logic [`PI1_AXI_ID_WIDTH-1:0] id;
		logic [`PI1_AXI_ARCHBITSZ-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

endpackage

//--- logic/pi1_axi_cfg.svh
//////////////////////////////
// Widths, SRAM depth and SRAM access latency.
//////////////////////////////
`ifndef PI1_AXI_CFG_SVH
`define PI1_AXI_CFG_SVH

`define PI1_AXI_ARCHBITSZ 32
// Word address, data width less the two byte-offset bits.
`define PI1_AXI_ADDRBITSZ 30
`define PI1_AXI_ID_WIDTH 4
`define PI1_AXI_MEM_WORDS 64
`define PI1_AXI_SRAM_LATENCY 2

`endif
